//--- hw/core_pkg.sv
// Core package for the RV32I integer pipeline
// Widths, opcode and ALU operation encodings, funct fields
`default_nettype none

package core_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int xlen       = 32;	// Data and PC width
	localparam int reg_addr_w = 5;	// Register index width
	localparam int num_regs   = 32;	// x0..x31

	//////////////////////////////////////////////////
	// Major opcodes handled by the pipeline
	//////////////////////////////////////////////////

	typedef enum logic [6:0] {
		op_reg   = 7'b0110011,	// R-type ALU
		op_imm   = 7'b0010011,	// I-type ALU, shifts included
		op_lui   = 7'b0110111,	// Load upper immediate
		op_auipc = 7'b0010111	// Add upper immediate to PC
	} opcode_t;

	// ALU operations, 4-bit code
	typedef enum logic [3:0] {
		alu_add    = 4'h0,
		alu_sub    = 4'h1,
		alu_sll    = 4'h2,
		alu_slt    = 4'h3,
		alu_sltu   = 4'h4,
		alu_xor    = 4'h5,
		alu_srl    = 4'h6,
		alu_sra    = 4'h7,
		alu_or     = 4'h8,
		alu_and    = 4'h9,
		alu_pass_b = 4'ha	// Operand B straight through, for LUI
	} alu_op_t;

	// funct3 values of OP and OP-IMM
	localparam logic [2:0] f3_add  = 3'b000;	// ADD, SUB, ADDI
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;	// SRL and SRA share it
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// funct7 selecting SUB and SRA
	localparam logic [6:0] f7_alt = 7'b0100000;

	// Source of an operand in decode
	typedef enum logic [1:0] {
		fwd_none = 2'd0,	// Register file
		fwd_exe  = 2'd1,	// ALU output of execute stage
		fwd_wb   = 2'd2		// Writeback register
	} fwd_sel_t;

endpackage : core_pkg

`default_nettype wire

//--- hw/alu.sv
// RV32I ALU
// add/sub, logic, signed and unsigned compare, shifts, pass-through of B
`default_nettype none
`timescale 1ns/10ps

module alu (
	input  logic [core_pkg::xlen-1:0] a,
	input  logic [core_pkg::xlen-1:0] b,
	input  core_pkg::alu_op_t         op,
	output logic [core_pkg::xlen-1:0] result
);

	import core_pkg::*;

	logic [4:0]      shamt;	// Low 5 bits of B
	logic            lt_signed;
	logic            lt_unsigned;
	logic [xlen-1:0] sum;
	logic [xlen-1:0] diff;

	assign shamt       = b[4:0];
	assign lt_signed   = ($signed(a) < $signed(b));
	assign lt_unsigned = (a < b);
	assign sum         = a + b;
	assign diff        = a - b;	// Wraps on overflow, no flag needed

	//////////////////////////////////////////////////
	// Result select
	//////////////////////////////////////////////////

	always_comb begin : alu_mux
		case (op)
			alu_add    : result = sum;
			alu_sub    : result = diff;
			alu_sll    : result = a << shamt;
			alu_slt    : result = {{(xlen-1){1'b0}}, lt_signed};
			alu_sltu   : result = {{(xlen-1){1'b0}}, lt_unsigned};
			alu_xor    : result = a ^ b;
			alu_srl    : result = a >> shamt;	// Zero fill
			alu_sra    : result = $signed(a) >>> shamt;	// Sign fill
			alu_or     : result = a | b;
			alu_and    : result = a & b;
			alu_pass_b : result = b;	// LUI
			default    : result = '0;
		endcase
	end : alu_mux

endmodule : alu

`default_nettype wire

//--- hw/reg_file.sv
// Integer register file, 32 x 32, two async reads, one sync write, x0 hardwired
`default_nettype none
`timescale 1ns/10ps

module reg_file (
	input  logic                            clk,
	input  logic                            nrst,
	input  logic [core_pkg::reg_addr_w-1:0] rd_addr1,
	input  logic [core_pkg::reg_addr_w-1:0] rd_addr2,
	input  logic [core_pkg::reg_addr_w-1:0] wr_addr,
	input  logic                            wr_en,
	input  logic [core_pkg::xlen-1:0]       wr_data,
	output logic [core_pkg::xlen-1:0]       rd_data1,
	output logic [core_pkg::xlen-1:0]       rd_data2
);

	import core_pkg::*;

	logic [xlen-1:0] regs [num_regs];

	// Write port
	always_ff @(posedge clk) begin : rf_write
		if (!nrst) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;	// All registers start at zero
		end
		else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;	// x0 writes dropped
		end
	end : rf_write

	// Read ports, combinational
	// Index 0 decoded explicitly so x0 reads zero regardless of contents
	assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
	assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule : reg_file

`default_nettype wire

//--- hw/instr_decoder.sv
// Instruction decoder, splits fields, builds the immediate and picks the ALU op
`default_nettype none
`timescale 1ns/10ps

module instr_decoder (
	input  logic [core_pkg::xlen-1:0]       instr,
	output logic [core_pkg::reg_addr_w-1:0] rs1,
	output logic [core_pkg::reg_addr_w-1:0] rs2,
	output logic [core_pkg::reg_addr_w-1:0] rd,
	output logic [core_pkg::xlen-1:0]       imm,
	output core_pkg::alu_op_t               alu_op,
	output logic                            use_imm,	// Operand B from immediate
	output logic                            use_pc,	// Operand A from PC (AUIPC)
	output logic                            writes_rd,
	output logic                            illegal
);

	import core_pkg::*;

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_base;	// funct7 all zero
	logic       f7_is_alt;	// funct7 selects SUB / SRA
	logic       known_op;
	logic       bad_f7;

	assign opcode    = opcode_t'(instr[6:0]);
	assign funct3    = instr[14:12];
	assign funct7    = instr[31:25];
	assign f7_base   = (funct7 == '0);
	assign f7_is_alt = (funct7 == f7_alt);

	// Fields and immediate, unused ones forced to zero
	always_comb begin : field_split
		rs1     = instr[19:15];
		rs2     = instr[24:20];
		rd      = instr[11:7];
		imm     = '0;
		use_imm = 1'b0;
		use_pc  = 1'b0;
		case (opcode)
			op_reg : begin
				// Both sources live, no immediate
			end
			op_imm : begin
				rs2     = '0;
				imm     = {{(xlen-12){instr[31]}}, instr[31:20]};	// Sign-extended I imm
				use_imm = 1'b1;
			end
			op_lui, op_auipc : begin
				rs1     = '0;
				rs2     = '0;
				imm     = {instr[31:12], 12'h000};	// Upper immediate
				use_imm = 1'b1;
				use_pc  = (opcode == op_auipc);
			end
			default : begin
				rs1 = '0;	// Unknown opcode reads and writes nothing
				rs2 = '0;
				rd  = '0;
			end
		endcase
	end : field_split

	//////////////////////////////////////////////////
	// ALU operation and legality
	//////////////////////////////////////////////////

	always_comb begin : alu_decode
		alu_op   = alu_add;
		known_op = 1'b1;
		bad_f7   = 1'b0;
		case (opcode)
			op_reg, op_imm : begin
				case (funct3)
					f3_add  : alu_op = (opcode == op_reg && f7_is_alt) ? alu_sub : alu_add;
					f3_sll  : alu_op = alu_sll;
					f3_slt  : alu_op = alu_slt;
					f3_sltu : alu_op = alu_sltu;
					f3_xor  : alu_op = alu_xor;
					f3_sr   : alu_op = f7_is_alt ? alu_sra : alu_srl;	// Bit 30 picks arithmetic
					f3_or   : alu_op = alu_or;
					default : alu_op = alu_and;
				endcase
				if (opcode == op_reg)
					// OP takes funct7 zero, or the alt value only on ADD/SUB and SRL/SRA
					bad_f7 = !(f7_base || (f7_is_alt && (funct3 == f3_add || funct3 == f3_sr)));
				else
					// Only the shift immediates constrain funct7
					bad_f7 = ((funct3 == f3_sll) && !f7_base) ||
						((funct3 == f3_sr) && !f7_base && !f7_is_alt);
			end
			op_lui   : alu_op = alu_pass_b;
			op_auipc : alu_op = alu_add;	// PC + upper imm
			default  : known_op = 1'b0;
		endcase
	end : alu_decode

	assign illegal   = !known_op || bad_f7;
	assign writes_rd = !illegal;	// Every legal op here writes rd

endmodule : instr_decoder

`default_nettype wire

//--- hw/operand_fetch.sv
// Operand fetch, register file read with forwarding from execute and writeback
`default_nettype none
`timescale 1ns/10ps

module operand_fetch (
	input  logic                            clk,
	input  logic                            nrst,
	input  logic [core_pkg::reg_addr_w-1:0] rs1,
	input  logic [core_pkg::reg_addr_w-1:0] rs2,
	input  logic [core_pkg::reg_addr_w-1:0] exe_rd,
	input  logic [core_pkg::reg_addr_w-1:0] wb_rd,
	input  logic                            exe_wr_en,
	input  logic                            wb_valid,
	input  logic [core_pkg::xlen-1:0]       exe_result,
	input  logic [core_pkg::xlen-1:0]       wb_data,
	output logic [core_pkg::xlen-1:0]       op_a,
	output logic [core_pkg::xlen-1:0]       op_b
);

	import core_pkg::*;

	logic [xlen-1:0] rf_a;	// Raw register file reads
	logic [xlen-1:0] rf_b;
	fwd_sel_t        sel_a;
	fwd_sel_t        sel_b;

	// Register file, written straight from the writeback registers
	reg_file u_reg_file (
		.clk      (clk),
		.nrst     (nrst),
		.rd_addr1 (rs1),
		.rd_addr2 (rs2),
		.wr_addr  (wb_rd),
		.wr_en    (wb_valid),
		.wr_data  (wb_data),
		.rd_data1 (rf_a),
		.rd_data2 (rf_b)
	);

	// Youngest producer wins, x0 never forwards
	function automatic fwd_sel_t pick_src(
		input logic [reg_addr_w-1:0] rs,
		input logic [reg_addr_w-1:0] e_rd,
		input logic                  e_wr,
		input logic [reg_addr_w-1:0] w_rd,
		input logic                  w_wr
	);
		if (rs == '0)
			return fwd_none;
		else if (e_wr && (e_rd == rs))
			return fwd_exe;	// Distance 1
		else if (w_wr && (w_rd == rs))
			return fwd_wb;	// Distance 2
		else
			return fwd_none;
	endfunction

	assign sel_a = pick_src(rs1, exe_rd, exe_wr_en, wb_rd, wb_valid);
	assign sel_b = pick_src(rs2, exe_rd, exe_wr_en, wb_rd, wb_valid);

	// Forwarding muxes
	always_comb begin : fwd_mux
		case (sel_a)
			fwd_exe : op_a = exe_result;
			fwd_wb  : op_a = wb_data;
			default : op_a = rf_a;
		endcase
		case (sel_b)
			fwd_exe : op_b = exe_result;
			fwd_wb  : op_b = wb_data;
			default : op_b = rf_b;
		endcase
	end : fwd_mux

	// x0 source reads zero through the whole path, even with x0 writes in flight
	a_x0_operand : assert property (
		@(posedge clk) disable iff (!nrst)
		((rs1 != '0) || (op_a == '0)) && ((rs2 != '0) || (op_b == '0))
	) else $error("Source x0 yields a nonzero operand");

endmodule : operand_fetch

`default_nettype wire

//--- hw/execute_stage.sv
// Execute stage, decode-to-execute registers, ALU and writeback registers
`default_nettype none
`timescale 1ns/10ps

module execute_stage (
	input  logic                            clk,
	input  logic                            nrst,
	input  logic                            instr_valid,
	input  logic [core_pkg::xlen-1:0]       instr_pc,
	input  logic [core_pkg::xlen-1:0]       op_a,
	input  logic [core_pkg::xlen-1:0]       op_b,
	input  logic [core_pkg::xlen-1:0]       imm,
	input  logic [core_pkg::reg_addr_w-1:0] rd,
	input  core_pkg::alu_op_t               alu_op,
	input  logic                            use_imm,
	input  logic                            use_pc,
	input  logic                            writes_rd,
	input  logic                            illegal,
	output logic [core_pkg::reg_addr_w-1:0] exe_rd,
	output logic                            exe_wr_en,
	output logic [core_pkg::xlen-1:0]       exe_result,
	output logic                            wb_valid,
	output logic [core_pkg::reg_addr_w-1:0] wb_rd,
	output logic [core_pkg::xlen-1:0]       wb_data,
	output logic                            illegal_instr
);

	import core_pkg::*;

	logic [xlen-1:0] exe_pc;
	logic [xlen-1:0] exe_op_a;
	logic [xlen-1:0] exe_op_b;
	logic [xlen-1:0] exe_imm;
	alu_op_t         exe_alu_op;
	logic            exe_use_imm;
	logic            exe_use_pc;
	logic            exe_illegal;	// Valid illegal instruction in execute
	logic [xlen-1:0] alu_a;
	logic [xlen-1:0] alu_b;

	//////////////////////////////////////////////////
	// Decode -> execute
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin : dec_exe_ctrl
		if (!nrst) begin
			exe_wr_en   <= 1'b0;
			exe_illegal <= 1'b0;
		end
		else begin
			exe_wr_en   <= instr_valid & writes_rd;	// Bubbles write nothing
			exe_illegal <= instr_valid & illegal;
		end
	end : dec_exe_ctrl

	// Payload, meaningful only under the control bits above
	always_ff @(posedge clk) begin : dec_exe_data
		exe_pc      <= instr_pc;
		exe_op_a    <= op_a;
		exe_op_b    <= op_b;
		exe_imm     <= imm;
		exe_rd      <= rd;
		exe_alu_op  <= alu_op;
		exe_use_imm <= use_imm;
		exe_use_pc  <= use_pc;
	end : dec_exe_data

	// Operand select
	assign alu_a = exe_use_pc ? exe_pc : exe_op_a;	// AUIPC takes the PC
	assign alu_b = exe_use_imm ? exe_imm : exe_op_b;

	alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (exe_alu_op),
		.result (exe_result)
	);

	//////////////////////////////////////////////////
	// Execute -> writeback
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin : exe_wb_ctrl
		if (!nrst) begin
			wb_valid      <= 1'b0;
			illegal_instr <= 1'b0;
		end
		else begin
			wb_valid      <= exe_wr_en;
			illegal_instr <= exe_illegal;	// Pulse in the slot of the lost writeback
		end
	end : exe_wb_ctrl

	always_ff @(posedge clk) begin : exe_wb_data
		wb_rd   <= exe_rd;
		wb_data <= exe_result;
	end : exe_wb_data

	// Retirement is either a write or a trap, never both
	a_wb_excl : assert property (
		@(posedge clk) disable iff (!nrst)
		!(wb_valid && illegal_instr)
	) else $error("wb_valid and illegal_instr high in the same cycle");

endmodule : execute_stage

`default_nettype wire

//--- hw/int_pipeline.sv
// RV32I integer pipeline top, decode and operand fetch feeding execute and writeback
`default_nettype none
`timescale 1ns/10ps

module int_pipeline (
	input  logic                            clk,
	input  logic                            nrst,
	input  logic                            instr_valid,
	input  logic [core_pkg::xlen-1:0]       instr,
	input  logic [core_pkg::xlen-1:0]       instr_pc,
	output logic                            wb_valid,
	output logic [core_pkg::reg_addr_w-1:0] wb_rd,
	output logic [core_pkg::xlen-1:0]       wb_data,
	output logic                            illegal_instr
);

	import core_pkg::*;

	// Decode outputs
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0]       imm;
	alu_op_t               alu_op;
	logic                  use_imm;
	logic                  use_pc;
	logic                  writes_rd;
	logic                  illegal;
	// Operand fetch outputs
	logic [xlen-1:0]       op_a;
	logic [xlen-1:0]       op_b;
	// Execute stage forwarding taps
	logic [reg_addr_w-1:0] exe_rd;
	logic                  exe_wr_en;
	logic [xlen-1:0]       exe_result;

	//////////////////////////////////////////////////
	// Decode stage, decoder and operand fetch in parallel
	//////////////////////////////////////////////////

	instr_decoder u_decoder (
		.instr     (instr),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.imm       (imm),
		.alu_op    (alu_op),
		.use_imm   (use_imm),
		.use_pc    (use_pc),
		.writes_rd (writes_rd),
		.illegal   (illegal)
	);

	operand_fetch u_operand_fetch (
		.clk        (clk),
		.nrst       (nrst),
		.rs1        (rs1),
		.rs2        (rs2),
		.exe_rd     (exe_rd),
		.wb_rd      (wb_rd),
		.exe_wr_en  (exe_wr_en),
		.wb_valid   (wb_valid),
		.exe_result (exe_result),
		.wb_data    (wb_data),	// Writeback also feeds the register file write port
		.op_a       (op_a),
		.op_b       (op_b)
	);

	// Execute and writeback
	execute_stage u_execute (
		.clk           (clk),
		.nrst          (nrst),
		.instr_valid   (instr_valid),
		.instr_pc      (instr_pc),
		.op_a          (op_a),
		.op_b          (op_b),
		.imm           (imm),
		.rd            (rd),
		.alu_op        (alu_op),
		.use_imm       (use_imm),
		.use_pc        (use_pc),
		.writes_rd     (writes_rd),
		.illegal       (illegal),
		.exe_rd        (exe_rd),
		.exe_wr_en     (exe_wr_en),
		.exe_result    (exe_result),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.illegal_instr (illegal_instr)
	);

endmodule : int_pipeline

`default_nettype wire

//--- verification/tb_clock.sv
// Testbench clock source
// Free-running clk with a 10 ns period
`default_nettype none
`timescale 1ns/10ps

module tb_clock (
	output logic clk
);

	initial begin : clk_gen
		clk = 1'b0;
		forever #5 clk = ~clk;	// Half period of 5 ns
	end : clk_gen

endmodule : tb_clock

`default_nettype wire

//--- verification/int_pipeline_tb.sv
// Testbench for the RV32I integer pipeline
// Random instruction stream checked against a reference register model
`default_nettype none
`timescale 1ns/10ps

module int_pipeline_tb;

	import core_pkg::*;

	// One slot of expected writeback, bubbles are all zero
	typedef struct packed {
		logic                  valid;	// wb_valid expected
		logic                  ill;	// illegal_instr expected
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       data;
	} expect_t;

	logic                  clk;
	logic                  nrst;
	logic                  instr_valid;
	logic [xlen-1:0]       instr;
	logic [xlen-1:0]       instr_pc;
	logic                  wb_valid;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0]       wb_data;
	logic                  illegal_instr;

	integer          seed;
	logic [xlen-1:0] ref_regs [num_regs];	// Architectural state at issue
	logic [xlen-1:0] pc;
	expect_t         exp_q [$];	// Two slots in flight
	expect_t         chk;	// Slot now on the DUT outputs
	int              issued;
	int              popped;
	int              retired;	// Strobes seen on the DUT outputs

	tb_clock u_clock (.clk(clk));

	int_pipeline UUT (
		.clk           (clk),
		.nrst          (nrst),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.instr_pc      (instr_pc),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.illegal_instr (illegal_instr)
	);

	task automatic report_mismatch(input string what);
		$display("[ERROR] %0t: %s", $time, what);
		$display("Test failures found");
		$fatal(1, "Writeback check failed");
	endtask

	task automatic abort_timeout(input string what);
		$display("Timeout: %s", what);
		$display("Test failures found");
		$fatal(1, "Wait loop timed out");
	endtask

	//////////////////////////////////////////////////
	// Output checks, fixed two-edge latency
	//////////////////////////////////////////////////

	a_wb_valid : assert property (@(posedge clk) disable iff (!nrst)
		wb_valid == chk.valid
	) else report_mismatch($sformatf("wb_valid is %0b, expected %0b",
		$sampled(wb_valid), $sampled(chk.valid)));

	a_wb_rd : assert property (@(posedge clk) disable iff (!nrst)
		chk.valid |-> (wb_rd == chk.rd)
	) else report_mismatch($sformatf("wb_rd is %0d, expected %0d",
		$sampled(wb_rd), $sampled(chk.rd)));

	a_wb_data : assert property (@(posedge clk) disable iff (!nrst)
		chk.valid |-> (wb_data == chk.data)
	) else report_mismatch($sformatf("wb_data for x%0d is %h, expected %h",
		$sampled(chk.rd), $sampled(wb_data), $sampled(chk.data)));

	a_illegal : assert property (@(posedge clk) disable iff (!nrst)
		illegal_instr == chk.ill
	) else report_mismatch($sformatf("illegal_instr is %0b, expected %0b",
		$sampled(illegal_instr), $sampled(chk.ill)));

	// Count every write or trap the DUT retires
	always @(posedge clk) begin : retire_count
		if (nrst && (wb_valid || illegal_instr))
			retired <= retired + 1;
	end : retire_count

	// RV32I result for a funct3 code, alt is bit 30 for SUB and SRA
	function automatic logic [xlen-1:0] model_alu(input logic [2:0] f3, input logic alt,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (f3)
			3'd0    : return alt ? a - b : a + b;
			3'd1    : return a << b[4:0];
			3'd2    : return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3    : return (a < b) ? 32'd1 : 32'd0;
			3'd4    : return a ^ b;
			3'd5    : begin
				if (alt)
					return $signed(a) >>> b[4:0];	// Sign fill
				else
					return a >> b[4:0];
			end
			3'd6    : return a | b;
			default : return a & b;
		endcase
	endfunction

	// Mostly x0..x7 so dependencies at short distance are frequent
	function automatic logic [4:0] pick_reg(input logic [6:0] bits);
		return (bits[6:5] == 2'b11) ? bits[4:0] : {2'b00, bits[2:0]};
	endfunction

	// Shift the expectation queue by one slot, once per driving edge
	task automatic push_expect(input expect_t e);
		if (exp_q.size() == 2) begin
			if (exp_q[0].valid || exp_q[0].ill)
				popped++;
			chk <= exp_q.pop_front();
		end
		exp_q.push_back(e);
		if (e.valid || e.ill)
			issued++;
	endtask

	task automatic drive_idle();
		instr_valid <= 1'b0;
		instr       <= $random(seed);	// Garbage on the bus, must be ignored
		push_expect('0);
	endtask

	task automatic drive_instr(input logic [xlen-1:0] word, input expect_t e);
		instr_valid <= 1'b1;
		instr       <= word;
		instr_pc    <= pc;
		push_expect(e);
		if (e.valid && e.rd != '0)
			ref_regs[e.rd] = e.data;	// x0 never changes
		pc = pc + 4;
	endtask

	//////////////////////////////////////////////////
	// Random instruction generator
	//////////////////////////////////////////////////

	task automatic issue_random();
		logic [31:0]     r;
		logic [31:0]     r2;
		logic [2:0]      f3;
		logic            alt;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [11:0]     imm12;
		logic [19:0]     imm20;
		logic [6:0]      opc;
		logic [xlen-1:0] word;
		expect_t         e;

		r     = $random(seed);
		r2    = $random(seed);
		f3    = r[6:4];
		alt   = r[7];
		imm12 = r[19:8];
		imm20 = r[27:8];
		rs1   = pick_reg(r2[6:0]);
		rs2   = pick_reg(r2[13:7]);
		rd    = pick_reg({r2[31:30], r2[24:20]});
		if (r2[15:14] == 2'b00)
			imm12 = r2[16] ? 12'h800 : 12'hfff;	// Immediate extremes
		if (r2[18:17] == 2'b00)
			imm20 = r2[19] ? 20'h80000 : 20'h7ffff;	// Upper extremes
		e      = '0;
		e.rd   = rd;
		e.valid = 1'b1;
		case (r[31:28])
			4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5 : begin	// R-type
				alt    = (f3 == 3'd0 || f3 == 3'd5) && alt;
				word   = {alt ? f7_alt : 7'b0, rs2, rs1, f3, rd, op_reg};
				e.data = model_alu(f3, alt, ref_regs[rs1], ref_regs[rs2]);
				drive_instr(word, e);
			end
			4'd6, 4'd7, 4'd8, 4'd9 : begin	// I-type
				if (f3 == 3'd1)
					imm12[11:5] = 7'b0;
				else if (f3 == 3'd5)
					imm12[11:5] = alt ? f7_alt : 7'b0;	// SRAI or SRLI
				alt    = (f3 == 3'd5) && alt;
				word   = {imm12, rs1, f3, rd, op_imm};
				e.data = model_alu(f3, alt, ref_regs[rs1],
					{{(xlen-12){imm12[11]}}, imm12});
				drive_instr(word, e);
			end
			4'd10 : begin
				e.data = {imm20, 12'h000};
				drive_instr({imm20, rd, op_lui}, e);
			end
			4'd11 : begin
				e.data = pc + {imm20, 12'h000};
				drive_instr({imm20, rd, op_auipc}, e);
			end
			4'd12 : begin	// Illegal encodings
				e.valid = 1'b0;
				e.ill   = 1'b1;
				case (r2[21:20])
					2'd0    : opc = 7'b0000011;
					2'd1    : opc = 7'b0100011;
					2'd2    : opc = 7'b1100011;
					default : opc = 7'b1101111;
				endcase
				case (r[3:2])
					2'd0    : word = {r2[31:7], opc};	// Opcode outside the pipeline
					2'd1    : word = {7'b0000001, rs2, rs1, f3, rd, op_reg};
					2'd2    : word = {f7_alt, r2[4:0], rs1, 3'b001, rd, op_imm};
					default : word = {7'b0000001, r2[4:0], rs1, 3'b101, rd, op_imm};
				endcase
				drive_instr(word, e);
			end
			default : drive_idle();
		endcase
	endtask

	initial begin : reset_gen
		nrst = 1'b0;
		repeat (10) @(posedge clk);
		nrst <= 1'b1;
	end : reset_gen

	initial begin : stimulus
		int wait_cyc;

		instr_valid = 1'b0;
		instr       = '0;
		instr_pc    = '0;
		seed        = 32'h1134e306;
		chk         = '0;
		issued      = 0;
		popped      = 0;
		retired     = 0;
		pc          = 32'h0000_4000;
		for (int i = 0; i < num_regs; i++)
			ref_regs[i] = '0;

		wait_cyc = 0;
		while (nrst !== 1'b1) begin
			@(posedge clk);
			wait_cyc++;
			if (wait_cyc > 20)
				abort_timeout("reset was not released");
		end

		for (int n = 0; n < 4000; n++) begin
			@(posedge clk);
			issue_random();
		end

		// Drain the last two slots
		wait_cyc = 0;
		while (popped < issued) begin
			@(posedge clk);
			drive_idle();
			wait_cyc++;
			if (wait_cyc > 10)
				abort_timeout("writeback queue did not drain");
		end
		@(posedge clk);	// Assertions sample the last writeback here
		drive_idle();
		#1;
		if (issued > 0 && retired == issued) begin
			$display("All tests passed!");
			$finish;
		end
		else begin
			$display("Test failures found");
			$fatal(1, "Retired and issued counts differ");
		end
	end : stimulus

endmodule : int_pipeline_tb

`default_nettype wire

//--- filelist.f
hw/core_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/instr_decoder.sv
hw/operand_fetch.sv
hw/execute_stage.sv
hw/int_pipeline.sv
verification/tb_clock.sv
verification/int_pipeline_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the integer pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module int_pipeline_tb \
	-f filelist.f \
	-o int_pipeline_sim

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/int_pipeline_sim
